// File: sim/load_stimulus.txt
# one load word per line in hex, feature byte then weight byte, 25 lines per session
# each session ends with one line of expected fill counts for lanes 0 1 2 3, decimal
# session 1
10f0
11ef
12ee
13ed
14ec
15eb
16ea
17e9
18e8
19e7
1ae6
1be5
1ce4
1de3
1ee2
1fe1
20e0
21df
22de
23dd
24dc
25db
26da
27d9
28d8
9 10 9 13
# session 2
5a3c
c391
07e2
9b44
2f18
e6a7
31cd
8804
74b9
d05e
1c63
a2f0
4b27
f97a
6e0d
0395
b8c1
5716
ca8f
29d3
9e40
62b5
fd09
846c
3ba8
9 10 9 13

// File: build.f
hdl/conv_load_pkg.sv
hdl/load_ctrl_fsm.sv
hdl/step_counter.sv
hdl/buff_en_decoder.sv
hdl/lane_buffer.sv
hdl/conv_load_top.sv
sim/tb_conv_load.sv

// File: run_sim.sh
#!/bin/sh
# build and run the operand loader testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -f build.f --top-module tb_conv_load \
    -o tb_conv_load > "$LOG" 2>&1 \
    && ./obj_dir/tb_conv_load >> "$LOG" 2>&1 \
    || echo "build or simulation returned an error, see $LOG"

cat "$LOG"

grep -qx "Result: PASSED" "$LOG" \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }

// File: sim/tb_conv_load.sv
`timescale 1ns/1ns

module tb_conv_load;

    localparam int DEPTH      = 16;
    localparam int IDX_W      = $clog2(DEPTH);
    localparam int CNT_W      = $clog2(DEPTH + 1);
    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DLY  = 5;
    localparam int SAMPLE_DLY = 10;
    localparam int TIMEOUT    = 100;

    typedef logic [CNT_W-1:0] cnt_t;

    logic                                           clk;
    logic                                           rst;
    logic                                           start;
    conv_load_pkg::load_word_t                      load_in;
    conv_load_pkg::lane_sel_t                       rd_lane;
    logic [IDX_W-1:0]                               rd_idx;
    logic                                           busy;
    logic                                           done;
    conv_load_pkg::rd_result_t                      rd_out;
    logic [conv_load_pkg::NUM_LANES-1:0][CNT_W-1:0] fill_cnt;

    // words of the current session, and the expected content of every lane
    conv_load_pkg::load_word_t words [conv_load_pkg::NUM_STEPS];
    conv_load_pkg::load_word_t lane_words [conv_load_pkg::NUM_LANES][DEPTH];
    cnt_t                      exp_cnt [conv_load_pkg::NUM_LANES];

    integer fd;

    conv_load_top #(
        .DEPTH (DEPTH)
    ) i_dut (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .load_in  (load_in),
        .rd_lane  (rd_lane),
        .rd_idx   (rd_idx),
        .busy     (busy),
        .done     (done),
        .rd_out   (rd_out),
        .fill_cnt (fill_cnt)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // reference copy of the lane pattern, grouped by mask
    function automatic conv_load_pkg::buff_en_t lane_mask(input int s);
        conv_load_pkg::buff_en_t m;
        case (s)
            0, 4, 10, 19, 24: m = 4'b1000;
            1, 12:            m = 4'b0100;
            2, 7, 14, 21:     m = 4'b0010;
            3, 17:            m = 4'b0001;
            5, 20:            m = 4'b1100;
            6, 13:            m = 4'b0110;
            8, 23:            m = 4'b1001;
            9, 18:            m = 4'b1101;
            11:               m = 4'b1110;
            15, 22:           m = 4'b0011;
            16:               m = 4'b1011;
            default:          m = 4'b0000;
        endcase
        return m;
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_error($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input cnt_t got, input cnt_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // payload only matters while the entry is valid
    task automatic check_result(input string name, input conv_load_pkg::rd_result_t got,
                                input conv_load_pkg::rd_result_t exp);
        bit bad;
        bad = exp.valid ? (got !== exp) : (got.valid !== 1'b0);
        if (bad) begin
            stop_with_error($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // inputs change a little after the rising edge
    task automatic step_clock();
        @(posedge clk);
        #(DRIVE_DLY);
    endtask

    // next line of the stimulus file, skipping comments and blank lines
    task automatic next_data_line(output string line, output bit found);
        int    code;
        string raw;
        found = 1'b0;
        line  = "";
        while (!found && !$feof(fd)) begin
            raw  = "";
            code = $fgets(raw, fd);
            if (code == 0) begin
                break;
            end
            if (raw.len() > 1 && raw[0] != "#") begin
                line  = raw;
                found = 1'b1;
            end
        end
    endtask

    task automatic read_session(input int sess);
        string       line;
        bit          found;
        int          n;
        logic [15:0] w;
        int          c0;
        int          c1;
        int          c2;
        int          c3;
        for (int s = 0; s < conv_load_pkg::NUM_STEPS; s++) begin
            next_data_line(line, found);
            n = 0;
            if (found) begin
                n = $sscanf(line, "%h", w);
            end
            if (n != 1) begin
                stop_with_error($sformatf("stimulus file has no word for session %0d step %0d",
                                          sess, s));
            end
            words[s] = conv_load_pkg::load_word_t'(w);
        end
        // one line of four counts closes the session
        next_data_line(line, found);
        n = 0;
        if (found) begin
            n = $sscanf(line, "%d %d %d %d", c0, c1, c2, c3);
        end
        if (n != 4) begin
            stop_with_error($sformatf("stimulus file has no fill counts for session %0d", sess));
        end
        exp_cnt[0] = cnt_t'(c0);
        exp_cnt[1] = cnt_t'(c1);
        exp_cnt[2] = cnt_t'(c2);
        exp_cnt[3] = cnt_t'(c3);
    endtask

    // walk the table to get each lane's entries in write order
    task automatic build_expected();
        int                      n [conv_load_pkg::NUM_LANES];
        conv_load_pkg::buff_en_t m;
        for (int j = 0; j < conv_load_pkg::NUM_LANES; j++) begin
            n[j] = 0;
        end
        for (int s = 0; s < conv_load_pkg::NUM_STEPS; s++) begin
            m = lane_mask(s);
            for (int j = 0; j < conv_load_pkg::NUM_LANES; j++) begin
                if (m[j]) begin
                    lane_words[j][n[j]] = words[s];
                    n[j]++;
                end
            end
        end
        // file counts and table counts have to agree
        for (int j = 0; j < conv_load_pkg::NUM_LANES; j++) begin
            if (cnt_t'(n[j]) != exp_cnt[j]) begin
                stop_with_error($sformatf(
                    "stimulus file expects %0d entries in lane %0d, table gives %0d",
                    exp_cnt[j], j, n[j]));
            end
        end
    endtask

    task automatic idle_gap();
        int unsigned n;
        n = $urandom_range(8, 2);
        repeat (n) begin
            step_clock();
        end
    endtask

    // poke_step puts a stray start into that busy cycle, -1 for none
    task automatic run_session(input int poke_step, input bit poke_done);
        int cyc;
        int busy_cycles;
        check_flag("busy", busy, 1'b0);
        start = 1'b1;
        step_clock();
        start       = 1'b0;
        cyc         = 0;
        busy_cycles = 0;
        while (done !== 1'b1) begin
            if (cyc >= TIMEOUT) begin
                stop_with_error($sformatf("timeout, done did not arrive within %0d cycles",
                                          TIMEOUT));
            end
            check_flag("busy", busy, 1'b1);
            if (busy_cycles >= conv_load_pkg::NUM_STEPS) begin
                stop_with_error("busy stayed high past the last step");
            end
            // word for step busy_cycles, written on the closing edge
            load_in = words[busy_cycles];
            start   = (busy_cycles == poke_step);
            busy_cycles++;
            step_clock();
            cyc++;
        end
        // done follows the 25th busy cycle directly
        check_flag("busy", busy, 1'b0);
        check_count("busy cycles", cnt_t'(busy_cycles), cnt_t'(conv_load_pkg::NUM_STEPS));
        load_in = '0;
        start   = poke_done;
        step_clock();
        start = 1'b0;
        // single cycle of done, and a start in done is dropped
        check_flag("done", done, 1'b0);
        check_flag("busy", busy, 1'b0);
    endtask

    task automatic check_readback();
        conv_load_pkg::rd_result_t exp;
        for (int j = 0; j < conv_load_pkg::NUM_LANES; j++) begin
            check_count($sformatf("fill_cnt[%0d]", j), fill_cnt[j], exp_cnt[j]);
        end
        for (int j = 0; j < conv_load_pkg::NUM_LANES; j++) begin
            for (int k = 0; k < DEPTH; k++) begin
                rd_lane = conv_load_pkg::lane_sel_t'(j);
                rd_idx  = IDX_W'(k);
                #(SAMPLE_DLY);
                exp = '0;
                exp.valid = (cnt_t'(k) < exp_cnt[j]);
                if (exp.valid) begin
                    exp.feature = lane_words[j][k].feature;
                    exp.weight  = lane_words[j][k].weight;
                end
                check_result($sformatf("rd_out lane %0d idx %0d", j, k), rd_out, exp);
                step_clock();
            end
        end
    endtask

    initial begin
        rst     = 1'b1;
        start   = 1'b0;
        load_in = '0;
        rd_lane = '0;
        rd_idx  = '0;
        // seed the generator once, it only spaces the sessions
        void'($urandom(76));
        fd = $fopen("sim/load_stimulus.txt", "r");
        if (fd == 0) begin
            stop_with_error("cannot open sim/load_stimulus.txt");
        end
        repeat (5) begin
            @(posedge clk);
        end
        #(DRIVE_DLY);
        rst = 1'b0;
        check_flag("busy", busy, 1'b0);
        check_flag("done", done, 1'b0);
        for (int j = 0; j < conv_load_pkg::NUM_LANES; j++) begin
            check_count($sformatf("fill_cnt[%0d]", j), fill_cnt[j], '0);
        end
        // first session gets a stray start mid load, second one in done
        for (int sess = 0; sess < 2; sess++) begin
            read_session(sess);
            build_expected();
            idle_gap();
            run_session((sess == 0) ? 10 : -1, sess == 1);
            check_readback();
        end
        $fclose(fd);
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: hdl/conv_load_top.sv
`timescale 1ns/1ns

module conv_load_top #(
    parameter int DEPTH = 16
) (
    input  logic                                                  clk,
    input  logic                                                  rst,
    input  logic                                                  start,
    input  conv_load_pkg::load_word_t                             load_in,
    input  conv_load_pkg::lane_sel_t                              rd_lane,
    input  logic [$clog2(DEPTH)-1:0]                              rd_idx,
    output logic                                                  busy,
    output logic                                                  done,
    output conv_load_pkg::rd_result_t                             rd_out,
    output logic [conv_load_pkg::NUM_LANES-1:0][$clog2(DEPTH+1)-1:0] fill_cnt
);

    localparam int CNT_W = $clog2(DEPTH + 1);

    // controller to counter and buffers
    logic count_en;
    logic clear;

    // counter to controller and decoder
    conv_load_pkg::step_t step;
    logic                 last;

    // decoder to lanes
    conv_load_pkg::buff_en_t buff_en;

    // per lane read data
    conv_load_pkg::feature_t feat_rd [conv_load_pkg::NUM_LANES];
    conv_load_pkg::weight_t  wgt_rd  [conv_load_pkg::NUM_LANES];

    load_ctrl_fsm i_ctrl (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .last     (last),
        .count_en (count_en),
        .clear    (clear),
        .busy     (busy),
        .done     (done)
    );

    step_counter i_step_cnt (
        .clk      (clk),
        .rst      (rst),
        .clear    (clear),
        .count_en (count_en),
        .step     (step),
        .last     (last)
    );

    buff_en_decoder i_en_dec (
        .step    (step),
        .buff_en (buff_en)
    );

    // the decoder shows step 0 while idle, so writes are gated by count_en
    for (genvar j = 0; j < conv_load_pkg::NUM_LANES; j++) begin : g_lane
        logic lane_wr;

        assign lane_wr = count_en && buff_en[j];

        lane_buffer #(
            .PAYLOAD_T (conv_load_pkg::feature_t),
            .DEPTH     (DEPTH)
        ) i_feat_buf (
            .clk     (clk),
            .rst     (rst),
            .clear   (clear),
            .wr_en   (lane_wr),
            .wr_data (load_in.feature),
            .rd_idx  (rd_idx),
            .rd_data (feat_rd[j]),
            .count   (fill_cnt[j])
        );

        // weight side fills in lockstep, its count mirrors the feature side
        lane_buffer #(
            .PAYLOAD_T (conv_load_pkg::weight_t),
            .DEPTH     (DEPTH)
        ) i_wgt_buf (
            .clk     (clk),
            .rst     (rst),
            .clear   (clear),
            .wr_en   (lane_wr),
            .wr_data (load_in.weight),
            .rd_idx  (rd_idx),
            .rd_data (wgt_rd[j]),
            .count   ()
        );
    end

    // read mux over the selected lane pair
    always_comb begin
        rd_out.feature = feat_rd[rd_lane];
        rd_out.weight  = wgt_rd[rd_lane];
        rd_out.valid   = CNT_W'(rd_idx) < fill_cnt[rd_lane];
    end

endmodule

// File: hdl/lane_buffer.sv
`timescale 1ns/1ns

module lane_buffer #(
    parameter type PAYLOAD_T = logic [7:0],
    parameter int  DEPTH     = 16
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       clear,
    input  logic                       wr_en,
    input  PAYLOAD_T                   wr_data,
    input  logic [$clog2(DEPTH)-1:0]   rd_idx,
    output PAYLOAD_T                   rd_data,
    output logic [$clog2(DEPTH+1)-1:0] count
);

    localparam int IDX_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    // entry storage, filled from index 0 upward
    PAYLOAD_T mem [DEPTH];

    logic full;
    logic wr_ok;

    assign full  = (count == CNT_W'(DEPTH));
    assign wr_ok = wr_en && !full;

    // fill count doubles as the write pointer
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (wr_ok) begin
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[count[IDX_W-1:0]] <= wr_data;
        end
    end

    // zero latency read, entries past count hold stale data
    assign rd_data = mem[rd_idx];

    // the lane pattern never overfills a buffer
    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> !full
    );

endmodule

// File: hdl/buff_en_decoder.sv
`timescale 1ns/1ns

module buff_en_decoder (
    input  conv_load_pkg::step_t    step,
    output conv_load_pkg::buff_en_t buff_en
);

    // fixed lane pattern of the 5x5 window
    // bit 3 is lane 3, each step writes to one to three lanes
    always_comb begin
        case (step)
            5'd0:    buff_en = 4'b1000;
            5'd1:    buff_en = 4'b0100;
            5'd2:    buff_en = 4'b0010;
            5'd3:    buff_en = 4'b0001;
            5'd4:    buff_en = 4'b1000;
            // second kernel row, lanes start to overlap
            5'd5:    buff_en = 4'b1100;
            5'd6:    buff_en = 4'b0110;
            5'd7:    buff_en = 4'b0010;
            5'd8:    buff_en = 4'b1001;
            5'd9:    buff_en = 4'b1101;
            5'd10:   buff_en = 4'b1000;
            5'd11:   buff_en = 4'b1110;
            5'd12:   buff_en = 4'b0100;
            5'd13:   buff_en = 4'b0110;
            5'd14:   buff_en = 4'b0010;
            5'd15:   buff_en = 4'b0011;
            5'd16:   buff_en = 4'b1011;
            5'd17:   buff_en = 4'b0001;
            5'd18:   buff_en = 4'b1101;
            5'd19:   buff_en = 4'b1000;
            // last row of the window
            5'd20:   buff_en = 4'b1100;
            5'd21:   buff_en = 4'b0010;
            5'd22:   buff_en = 4'b0011;
            5'd23:   buff_en = 4'b1001;
            5'd24:   buff_en = 4'b1000;
            // outside the window nothing is written
            default: buff_en = 4'b0000;
        endcase
    end

    // every in-window step feeds at least one lane
    always_comb begin
        if (step < conv_load_pkg::step_t'(conv_load_pkg::NUM_STEPS)) begin
            a_mask_nonzero: assert (buff_en != '0);
        end
    end

endmodule

// File: hdl/step_counter.sv
`timescale 1ns/1ns

module step_counter (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 clear,
    input  logic                 count_en,
    output conv_load_pkg::step_t step,
    output logic                 last
);

    // final step index of a session
    localparam conv_load_pkg::step_t LAST_STEP =
        conv_load_pkg::step_t'(conv_load_pkg::NUM_STEPS - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            step <= '0;
        end else if (clear) begin
            // new session starts from step 0
            step <= '0;
        end else if (count_en) begin
            // wrap so the counter rests at 0 between sessions
            if (step == LAST_STEP) begin
                step <= '0;
            end else begin
                step <= step + 1'b1;
            end
        end
    end

    // only a live step 24 counts as last, a parked counter never does
    assign last = count_en && (step == LAST_STEP);

    // counter stays inside the kernel window
    a_step_in_range: assert property (
        @(posedge clk) disable iff (rst)
        step <= LAST_STEP
    );

endmodule

// File: hdl/load_ctrl_fsm.sv
`timescale 1ns/1ns

module load_ctrl_fsm (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic last,
    output logic count_en,
    output logic clear,
    output logic busy,
    output logic done
);

    // idle waits for start, load runs the 25 steps, done is a single cycle
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_LOAD = 2'd1,
        ST_DONE = 2'd2
    } state_t;

    state_t state;
    state_t state_nxt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            // start is only taken from idle
            ST_IDLE: begin
                if (start) begin
                    state_nxt = ST_LOAD;
                end
            end
            // last marks step 24, the final write of the session
            ST_LOAD: begin
                if (last) begin
                    state_nxt = ST_DONE;
                end
            end
            ST_DONE: begin
                state_nxt = ST_IDLE;
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    // clear fires in the accept cycle so the counter and buffers
    // are empty on the first load cycle
    assign clear = (state == ST_IDLE) && start;

    // counter advances and lanes write only while loading
    assign count_en = (state == ST_LOAD);
    assign busy     = (state == ST_LOAD);
    assign done     = (state == ST_DONE);

    // done only follows the last step of a load
    a_done_after_last: assert property (
        @(posedge clk) disable iff (rst)
        $rose(done) |-> $past((state == ST_LOAD) && last)
    );

endmodule

// File: hdl/conv_load_pkg.sv
package conv_load_pkg;

    // one session walks a 5x5 kernel window
    localparam int NUM_STEPS = 25;

    // four operand lanes, each with a feature and a weight buffer
    localparam int NUM_LANES = 4;

    // step index, 0 to 24
    typedef logic [4:0] step_t;

    // lane enable mask, bit j drives lane j
    typedef logic [NUM_LANES-1:0] buff_en_t;

    // raw operand types
    typedef logic [7:0] feature_t;
    typedef logic [7:0] weight_t;

    // lane index for the read port
    typedef logic [1:0] lane_sel_t;

    // input word of one step, feature in the upper byte
    typedef struct packed {
        feature_t feature;
        weight_t  weight;
    } load_word_t;

    // read port result
    // valid is low when the index is past the lane's fill count
    typedef struct packed {
        logic     valid;
        feature_t feature;
        weight_t  weight;
    } rd_result_t;

endpackage
